// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_ex_stage
FILELIST  ?= sim.f

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
+incdir+src
src/ex_isa_pkg.sv
src/ex_pipe_pkg.sv
src/ex_slot_if.sv
src/ex_decode.sv
src/ex_alu.sv
src/ex_commit.sv
src/ex_stage.sv
tests/tb_clock_gen.sv
tests/ex_stage_chk.sv
tests/tb_ex_stage.sv

// ==== src/ex_alu.sv ====
`timescale 1ns/10ps

`include "ex_macros.svh"

module ex_alu (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                stage_en_i,
    // arithmetic / logic
    input  ex_isa_pkg::alu_op_e op_i,
    input  logic [`EX_XLEN-1:0] left_i,
    input  logic [`EX_XLEN-1:0] right_i,
    output logic [`EX_XLEN-1:0] result_o,
    // branch compare
    input  ex_isa_pkg::cmp_op_e cmp_op_i,
    input  logic [`EX_XLEN-1:0] cmp_left_i,
    input  logic [`EX_XLEN-1:0] cmp_right_i,
    output logic                cmp_o
);

    import ex_isa_pkg::*;

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [`EX_XLEN-1:0] result_d;
    logic                cmp_d;

    assign shamt = right_i[SHAMT_W-1:0];

    // --------------------------------------------------
    // operation select
    // --------------------------------------------------
    always_comb begin
        case (op_i)
            ADD:     result_d = left_i + right_i;
            SUB:     result_d = left_i - right_i;
            SLL:     result_d = left_i << shamt;
            SLT:     result_d = {{(`EX_XLEN-1){1'b0}}, $signed(left_i) < $signed(right_i)};
            SLTU:    result_d = {{(`EX_XLEN-1){1'b0}}, left_i < right_i};
            XOR:     result_d = left_i ^ right_i;
            SRL:     result_d = left_i >> shamt;
            SRA:     result_d = $unsigned($signed(left_i) >>> shamt);
            OR:      result_d = left_i | right_i;
            AND:     result_d = left_i & right_i;
            default: result_d = '0;
        endcase
    end

    // branch compare
    always_comb begin
        case (cmp_op_i)
            BEQ:     cmp_d = (cmp_left_i == cmp_right_i);
            BNE:     cmp_d = (cmp_left_i != cmp_right_i);
            BLT:     cmp_d = ($signed(cmp_left_i) <  $signed(cmp_right_i));
            BGE:     cmp_d = ($signed(cmp_left_i) >= $signed(cmp_right_i));
            BLTU:    cmp_d = (cmp_left_i <  cmp_right_i);
            BGEU:    cmp_d = (cmp_left_i >= cmp_right_i);
            default: cmp_d = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // result registers, aligned with the slot
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmp_o <= 1'b0;
        end else if (stage_en_i) begin
            cmp_o <= cmp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            result_o <= result_d;
        end
    end

endmodule

// ==== src/ex_commit.sv ====
`timescale 1ns/10ps

`include "ex_macros.svh"

module ex_commit (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // held instruction and its results
    ex_slot_if.commit            slot,
    input  logic [`EX_XLEN-1:0]  alu_result_i,
    input  logic                 cmp_i,
    // incoming instruction, for stream tracking
    input  ex_pipe_pkg::sofid_e  sofid_i,
    input  logic                 in_valid_i,
    // load/store queue back-pressure
    input  logic                 lsq_full_i,
    // stage control
    output logic                 stage_en_o,
    output logic                 stall_o,
    // write-back
    output logic                 regd_wr_o,
    output logic                 regd_cncl_load_o,
    output logic [`EX_XLEN-1:0]  regd_data_o,
    // load/store queue writes
    output logic                 lq_wr_o,
    output logic                 sq_wr_o,
    // fetch redirect
    output logic                 jump_o,
    output logic [`EX_XLEN-1:0]  jump_addr_o
);

    import ex_pipe_pkg::*;

    sofid_e sofid_q;
    logic   ex_valid;
    logic   commit;
    logic   jump;

    // --------------------------------------------------
    // qualification
    // --------------------------------------------------
    assign ex_valid = slot.valid & (sofid_q == SOFID_RUN);
    // unconditional, or compare came out true
    assign commit   = ex_valid & (cmp_i | ~slot.cond);
    assign jump     = commit & slot.jump;

    // --------------------------------------------------
    // stall control
    // --------------------------------------------------
    // only a committing queue access waits on a full queue
    assign stall_o    = commit & lsq_full_i & (slot.lq_wr | slot.sq_wr);
    assign stage_en_o = ~stall_o;

    // --------------------------------------------------
    // stream tracking
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sofid_q <= SOFID_RUN;
        end else if (stage_en_o) begin
            if (jump) begin
                sofid_q <= SOFID_JUMP;
            end else if (in_valid_i && sofid_i == SOFID_JUMP) begin
                // first instruction of the new stream arrives
                sofid_q <= SOFID_RUN;
            end
        end
    end

    // --------------------------------------------------
    // commit strobes
    // --------------------------------------------------
    assign regd_wr_o = stage_en_o & commit & slot.regd_wr;
    assign lq_wr_o   = stage_en_o & commit & slot.lq_wr;
    assign sq_wr_o   = stage_en_o & commit & slot.sq_wr;
    assign jump_o    = stage_en_o & jump;

    // load dropped by a stream change or a false condition
    assign regd_cncl_load_o = stage_en_o & ~commit & slot.valid & slot.lq_wr;

    // --------------------------------------------------
    // data paths
    // --------------------------------------------------
    // linking instructions write back the return address
    always_comb begin
        if (slot.link) begin
            regd_data_o = slot.pc_inc;
        end else begin
            regd_data_o = alu_result_i;
        end
    end

    assign jump_addr_o = {alu_result_i[`EX_XLEN-1:1], 1'b0};

endmodule

// ==== src/ex_decode.sv ====
`timescale 1ns/10ps

`include "ex_macros.svh"

module ex_decode (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      stage_en_i,
    // instruction from decode stage
    input  logic                      valid_i,
    input  logic                      jump_i,
    input  logic                      cond_i,
    input  logic                      link_i,
    input  ex_isa_pkg::zone_e         zone_i,
    input  logic [`EX_XLEN-1:0]       pc_i,
    input  logic [`EX_INS_SIZE_W-1:0] ins_size_i,
    input  logic [`EX_XLEN-1:0]       regs2_data_i,
    input  logic [`EX_REG_ADDR_W-1:0] regd_addr_i,
    input  logic [`EX_FUNCT3_W-1:0]   funct3_i,
    // registered slot
    ex_slot_if.decode                 slot
);

    import ex_isa_pkg::*;

    // size is in halfwords, so shift left by one for bytes
    logic [`EX_XLEN-1:0] size_bytes;

    assign size_bytes = {{(`EX_XLEN-`EX_INS_SIZE_W-1){1'b0}}, ins_size_i, 1'b0};

    // --------------------------------------------------
    // slot valid
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slot.valid <= 1'b0;
        end else if (stage_en_i) begin
            slot.valid <= valid_i;
        end
    end

    // --------------------------------------------------
    // slot payload
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            slot.jump       <= jump_i;
            slot.cond       <= cond_i;
            slot.link       <= link_i;
            slot.pc_inc     <= pc_i + size_bytes;
            slot.regs2_data <= regs2_data_i;
            slot.regd_addr  <= regd_addr_i;
            slot.funct3     <= funct3_i;
            // zone to one-hot write flags
            slot.lq_wr      <= (zone_i == ZONE_LOADQ);
            slot.sq_wr      <= (zone_i == ZONE_STOREQ);
            slot.regd_wr    <= (zone_i == ZONE_REGFILE);
        end
    end

endmodule

// ==== src/ex_isa_pkg.sv ====
`include "ex_macros.svh"

package ex_isa_pkg;

    // ----------------------------------------------------
    // alu operations
    // ----------------------------------------------------
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    // branch compares, encoded as the branch funct3 field
    typedef enum logic [`EX_FUNCT3_W-1:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } cmp_op_e;

    // access sizes seen on funct3 of loads and stores
    typedef enum logic [`EX_FUNCT3_W-1:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } access_size_e;

    // destination of the instruction result
    typedef enum logic [1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_REGFILE = 2'd1,
        ZONE_LOADQ   = 2'd2,
        ZONE_STOREQ  = 2'd3
    } zone_e;

endpackage

// ==== src/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// ----------------------------------------------------
// datapath widths
// ----------------------------------------------------

// data and address width
`define EX_XLEN 32

// register file index
`define EX_REG_ADDR_W 5

// load/store size and sign field
`define EX_FUNCT3_W 3

// instruction size counted in halfwords
`define EX_INS_SIZE_W 2

`endif

// ==== src/ex_pipe_pkg.sv ====
package ex_pipe_pkg;

    // ----------------------------------------------------
    // stream tracking
    // ----------------------------------------------------

    // run   current stream executes
    // jump  waiting for the first instruction of the new stream
    //
    // decode tags the first instruction after a jump with
    // SOFID_JUMP, all others with SOFID_RUN
    typedef enum logic {
        SOFID_RUN  = 1'b0,
        SOFID_JUMP = 1'b1
    } sofid_e;

endpackage

// ==== src/ex_slot_if.sv ====
`timescale 1ns/10ps

`include "ex_macros.svh"

// registered instruction slot, decode side to commit side
interface ex_slot_if;

    // control
    logic                      valid;
    logic                      jump;
    logic                      cond;
    logic                      link;

    // one-hot destination flags from the zone
    logic                      lq_wr;
    logic                      sq_wr;
    logic                      regd_wr;

    // payload
    logic [`EX_XLEN-1:0]       pc_inc;
    logic [`EX_REG_ADDR_W-1:0] regd_addr;
    logic [`EX_XLEN-1:0]       regs2_data;
    logic [`EX_FUNCT3_W-1:0]   funct3;

    modport decode (
        output valid, jump, cond, link,
        output lq_wr, sq_wr, regd_wr,
        output pc_inc, regd_addr, regs2_data, funct3
    );

    modport commit (
        input  valid, jump, cond, link,
        input  lq_wr, sq_wr, regd_wr,
        input  pc_inc, regd_addr, regs2_data, funct3
    );

endinterface

// ==== src/ex_stage.sv ====
`timescale 1ns/10ps

`include "ex_macros.svh"

module ex_stage (
    input  logic                      clk_i,
    input  logic                      reset_i,
    // decode stage, instruction in
    input  logic                      ids_valid_i,
    input  ex_pipe_pkg::sofid_e       ids_sofid_i,
    input  logic [`EX_INS_SIZE_W-1:0] ids_ins_size_i,
    input  logic                      ids_jump_i,
    input  logic                      ids_cond_i,
    input  ex_isa_pkg::zone_e         ids_zone_i,
    input  logic                      ids_link_i,
    input  logic [`EX_XLEN-1:0]       ids_pc_i,
    input  ex_isa_pkg::alu_op_e       ids_alu_op_i,
    input  logic [`EX_XLEN-1:0]       ids_operand_left_i,
    input  logic [`EX_XLEN-1:0]       ids_operand_right_i,
    input  logic [`EX_XLEN-1:0]       ids_cmp_right_i,
    input  logic [`EX_XLEN-1:0]       ids_regs1_data_i,
    input  logic [`EX_XLEN-1:0]       ids_regs2_data_i,
    input  logic [`EX_REG_ADDR_W-1:0] ids_regd_addr_i,
    input  logic [`EX_FUNCT3_W-1:0]   ids_funct3_i,
    // decode stage, stall and write-back
    output logic                      ids_stall_o,
    output logic                      ids_regd_wr_o,
    output logic [`EX_REG_ADDR_W-1:0] ids_regd_addr_o,
    output logic [`EX_XLEN-1:0]       ids_regd_data_o,
    output logic                      ids_regd_cncl_load_o,
    // fetch unit
    output logic                      pfu_jump_o,
    output logic [`EX_XLEN-1:0]       pfu_jump_addr_o,
    // load/store queue
    input  logic                      lsq_full_i,
    output logic                      lsq_lq_wr_o,
    output logic                      lsq_sq_wr_o,
    output logic [`EX_FUNCT3_W-1:0]   lsq_funct3_o,
    output logic [`EX_REG_ADDR_W-1:0] lsq_regd_addr_o,
    output logic [`EX_XLEN-1:0]       lsq_regs2_data_o,
    output logic [`EX_XLEN-1:0]       lsq_addr_o
);

    import ex_isa_pkg::*;

    logic                stage_en;
    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_cmp;

    ex_slot_if slot ();

    // --------------------------------------------------
    // instruction register
    // --------------------------------------------------
    ex_decode i_ex_decode (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .stage_en_i   (stage_en),
        .valid_i      (ids_valid_i),
        .jump_i       (ids_jump_i),
        .cond_i       (ids_cond_i),
        .link_i       (ids_link_i),
        .zone_i       (ids_zone_i),
        .pc_i         (ids_pc_i),
        .ins_size_i   (ids_ins_size_i),
        .regs2_data_i (ids_regs2_data_i),
        .regd_addr_i  (ids_regd_addr_i),
        .funct3_i     (ids_funct3_i),
        .slot         (slot.decode)
    );

    // branch funct3 doubles as the compare opcode
    ex_alu i_ex_alu (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .stage_en_i  (stage_en),
        .op_i        (ids_alu_op_i),
        .left_i      (ids_operand_left_i),
        .right_i     (ids_operand_right_i),
        .result_o    (alu_result),
        .cmp_op_i    (cmp_op_e'(ids_funct3_i)),
        .cmp_left_i  (ids_regs1_data_i),
        .cmp_right_i (ids_cmp_right_i),
        .cmp_o       (alu_cmp)
    );

    ex_commit i_ex_commit (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .slot             (slot.commit),
        .alu_result_i     (alu_result),
        .cmp_i            (alu_cmp),
        .sofid_i          (ids_sofid_i),
        .in_valid_i       (ids_valid_i),
        .lsq_full_i       (lsq_full_i),
        .stage_en_o       (stage_en),
        .stall_o          (ids_stall_o),
        .regd_wr_o        (ids_regd_wr_o),
        .regd_cncl_load_o (ids_regd_cncl_load_o),
        .regd_data_o      (ids_regd_data_o),
        .lq_wr_o          (lsq_lq_wr_o),
        .sq_wr_o          (lsq_sq_wr_o),
        .jump_o           (pfu_jump_o),
        .jump_addr_o      (pfu_jump_addr_o)
    );

    // --------------------------------------------------
    // slot fields straight out
    // --------------------------------------------------
    assign ids_regd_addr_o  = slot.regd_addr;
    assign lsq_regd_addr_o  = slot.regd_addr;
    assign lsq_funct3_o     = slot.funct3;
    assign lsq_regs2_data_o = slot.regs2_data;
    assign lsq_addr_o       = alu_result;

endmodule

// ==== tests/ex_stage_chk.sv ====
`timescale 1ns/10ps

module ex_stage_chk (
    input logic clk_i,
    input logic reset_i,
    input logic ids_stall_o,
    input logic ids_regd_wr_o,
    input logic ids_regd_cncl_load_o,
    input logic pfu_jump_o,
    input logic lsq_lq_wr_o,
    input logic lsq_sq_wr_o
);

    int unsigned fail_count = 0;

    logic write_strobes;
    logic any_strobe;

    assign write_strobes = ids_regd_wr_o | lsq_lq_wr_o | lsq_sq_wr_o;
    assign any_strobe    = write_strobes | pfu_jump_o | ids_regd_cncl_load_o;

    // stage holds while stalled
    stall_no_write: assert property (@(posedge clk_i) disable iff (reset_i)
        ids_stall_o |-> !write_strobes)
        else begin
            $error("write strobe while the stage is stalled");
            fail_count++;
        end

    // one zone per instruction
    queue_one_hot: assert property (@(posedge clk_i) disable iff (reset_i)
        !(lsq_lq_wr_o && lsq_sq_wr_o))
        else begin
            $error("load and store queue written together");
            fail_count++;
        end

    // slot is empty right after reset
    reset_quiet: assert property (@(posedge clk_i) $fell(reset_i) |-> !any_strobe)
        else begin
            $error("strobe in the first cycle after reset");
            fail_count++;
        end

endmodule

bind ex_stage ex_stage_chk i_ex_stage_chk (.*);

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== tests/tb_ex_stage.sv ====
`timescale 1ns/10ps

`include "ex_macros.svh"

module tb_ex_stage;

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam int CLK_PERIOD_NS = 100;
    localparam int NUM_TESTS     = 5;

    logic                      clk_i;
    logic                      reset_i;
    logic                      ids_valid_i, ids_jump_i, ids_cond_i, ids_link_i;
    sofid_e                    ids_sofid_i;
    zone_e                     ids_zone_i;
    alu_op_e                   ids_alu_op_i;
    logic [`EX_INS_SIZE_W-1:0] ids_ins_size_i;
    logic [`EX_XLEN-1:0]       ids_pc_i, ids_operand_left_i, ids_operand_right_i;
    logic [`EX_XLEN-1:0]       ids_cmp_right_i, ids_regs1_data_i, ids_regs2_data_i;
    logic [`EX_REG_ADDR_W-1:0] ids_regd_addr_i, ids_regd_addr_o, lsq_regd_addr_o;
    logic [`EX_FUNCT3_W-1:0]   ids_funct3_i, lsq_funct3_o;
    logic                      ids_stall_o, ids_regd_wr_o, ids_regd_cncl_load_o;
    logic [`EX_XLEN-1:0]       ids_regd_data_o, pfu_jump_addr_o;
    logic [`EX_XLEN-1:0]       lsq_regs2_data_o, lsq_addr_o;
    logic                      pfu_jump_o, lsq_full_i, lsq_lq_wr_o, lsq_sq_wr_o;

    int     errors   = 0;
    int     checks   = 0;
    integer seed     = 67096;
    // stream tag for the next instruction, as decode would mark it
    sofid_e next_tag = SOFID_RUN;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) i_tb_clock_gen (.clk_o(clk_i));

    ex_stage i_ex_stage (.*);

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_data(input string name, input logic [`EX_XLEN-1:0] exp,
                              input logic [`EX_XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // only the strobe of the given zone may be high
    task automatic check_zone_strobes(input zone_e zone);
        check_bit("ids_regd_wr_o", zone == ZONE_REGFILE, ids_regd_wr_o);
        check_bit("lsq_lq_wr_o", zone == ZONE_LOADQ, lsq_lq_wr_o);
        check_bit("lsq_sq_wr_o", zone == ZONE_STOREQ, lsq_sq_wr_o);
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        logic       lt_signed;
        sh = b[4:0];
        lt_signed = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << sh;
            SLT:     return {31'b0, lt_signed};
            SLTU:    return {31'b0, a < b};
            XOR:     return a ^ b;
            SRL:     return a >> sh;
            SRA:     return a[31] ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh);
            OR:      return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input cmp_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
        logic lt_signed;
        lt_signed = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return lt_signed;
            BGE:     return !lt_signed;
            BLTU:    return a < b;
            default: return !(a < b);
        endcase
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // called just after a rising edge
    task automatic present_instruction(input logic jump, input logic cond, input logic link,
                                       input zone_e zone, input alu_op_e op);
        logic [31:0] rnd;
        rnd = $random(seed);
        ids_valid_i         <= 1'b1;
        ids_sofid_i         <= next_tag;
        next_tag             = SOFID_RUN;
        ids_jump_i          <= jump;
        ids_cond_i          <= cond;
        ids_link_i          <= link;
        ids_zone_i          <= zone;
        ids_alu_op_i        <= op;
        ids_ins_size_i      <= rnd[1:0];
        ids_regd_addr_i     <= rnd[8:4];
        ids_funct3_i        <= rnd[14:12];
        ids_pc_i            <= $random(seed);
        ids_operand_left_i  <= $random(seed);
        ids_operand_right_i <= $random(seed);
        ids_cmp_right_i     <= $random(seed);
        ids_regs1_data_i    <= $random(seed);
        ids_regs2_data_i    <= $random(seed);
    endtask

    // edge that accepts the instruction, then the falling edge for checks
    task automatic accept_and_settle;
        @(posedge clk_i);
        ids_valid_i <= 1'b0;
        @(negedge clk_i);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic alu_writeback;
        alu_op_e op;
        op = op.first();
        repeat (op.num()) begin
            @(posedge clk_i);
            present_instruction(1'b0, 1'b0, 1'b0, ZONE_REGFILE, op);
            accept_and_settle();
            check_zone_strobes(ZONE_REGFILE);
            check_data("ids_regd_data_o",
                       alu_model(op, ids_operand_left_i, ids_operand_right_i), ids_regd_data_o);
            check_data("ids_regd_addr_o", 32'(ids_regd_addr_i), 32'(ids_regd_addr_o));
            op = op.next();
        end
    endtask

    task automatic branch_compare;
        cmp_op_e     op;
        logic [31:0] base;
        logic [31:0] lhs [3];
        logic [31:0] rhs [3];
        logic        taken;
        op = op.first();
        repeat (op.num()) begin
            base = $random(seed);
            base[31:30] = 2'b00;
            // equal, one apart, positive against negative
            lhs = '{base, base, base};
            rhs = '{base, base + 1, base | 32'h8000_0000};
            for (int i = 0; i < 3; i++) begin
                taken = branch_taken(op, lhs[i], rhs[i]);
                @(posedge clk_i);
                present_instruction(1'b1, 1'b1, 1'b0, ZONE_NONE, ADD);
                ids_funct3_i     <= op;
                ids_regs1_data_i <= lhs[i];
                ids_cmp_right_i  <= rhs[i];
                accept_and_settle();
                check_bit("pfu_jump_o", taken, pfu_jump_o);
                check_data("pfu_jump_addr_o",
                           (ids_operand_left_i + ids_operand_right_i) & ~32'h1, pfu_jump_addr_o);
                check_zone_strobes(ZONE_NONE);
                if (taken) begin
                    next_tag = SOFID_JUMP;
                end
            end
            op = op.next();
        end
    endtask

    task automatic jump_and_link;
        logic [31:0] ret_addr;
        @(posedge clk_i);
        present_instruction(1'b1, 1'b0, 1'b1, ZONE_REGFILE, ADD);
        accept_and_settle();
        ret_addr = ids_pc_i + (32'(ids_ins_size_i) << 1);
        check_bit("pfu_jump_o", 1'b1, pfu_jump_o);
        check_data("pfu_jump_addr_o",
                   (ids_operand_left_i + ids_operand_right_i) & ~32'h1, pfu_jump_addr_o);
        check_zone_strobes(ZONE_REGFILE);
        check_data("ids_regd_data_o", ret_addr, ids_regd_data_o);
        // old stream alu op is dropped and a load is cancelled
        for (int i = 0; i < 2; i++) begin
            @(posedge clk_i);
            present_instruction(1'b0, 1'b0, 1'b0, (i == 0) ? ZONE_REGFILE : ZONE_LOADQ, SUB);
            accept_and_settle();
            check_zone_strobes(ZONE_NONE);
            check_bit("pfu_jump_o", 1'b0, pfu_jump_o);
            check_bit("ids_regd_cncl_load_o", i == 1, ids_regd_cncl_load_o);
        end
        // first instruction of the new stream
        next_tag = SOFID_JUMP;
        @(posedge clk_i);
        present_instruction(1'b0, 1'b0, 1'b0, ZONE_REGFILE, OR);
        accept_and_settle();
        check_zone_strobes(ZONE_REGFILE);
        check_data("ids_regd_data_o",
                   alu_model(OR, ids_operand_left_i, ids_operand_right_i), ids_regd_data_o);
    endtask

    task automatic load_store_access;
        zone_e zone;
        zone = ZONE_LOADQ;
        repeat (2) begin
            @(posedge clk_i);
            present_instruction(1'b0, 1'b0, 1'b0, zone, ADD);
            accept_and_settle();
            check_zone_strobes(zone);
            check_bit("ids_regd_cncl_load_o", 1'b0, ids_regd_cncl_load_o);
            check_data("lsq_addr_o", ids_operand_left_i + ids_operand_right_i, lsq_addr_o);
            check_data("lsq_funct3_o", 32'(ids_funct3_i), 32'(lsq_funct3_o));
            check_data("lsq_regd_addr_o", 32'(ids_regd_addr_i), 32'(lsq_regd_addr_o));
            check_data("lsq_regs2_data_o", ids_regs2_data_i, lsq_regs2_data_o);
            zone = ZONE_STOREQ;
        end
    endtask

    task automatic queue_back_pressure;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        @(posedge clk_i);
        lsq_full_i <= 1'b1;
        present_instruction(1'b0, 1'b0, 1'b0, ZONE_STOREQ, ADD);
        // store accepted here, next instruction waits at the inputs
        @(posedge clk_i);
        exp_addr = ids_operand_left_i + ids_operand_right_i;
        exp_data = ids_regs2_data_i;
        present_instruction(1'b0, 1'b0, 1'b0, ZONE_REGFILE, XOR);
        repeat (2) begin
            @(negedge clk_i);
            check_bit("ids_stall_o", 1'b1, ids_stall_o);
            check_zone_strobes(ZONE_NONE);
            @(posedge clk_i);
        end
        lsq_full_i <= 1'b0;
        @(negedge clk_i);
        check_bit("ids_stall_o", 1'b0, ids_stall_o);
        check_zone_strobes(ZONE_STOREQ);
        check_data("lsq_addr_o", exp_addr, lsq_addr_o);
        check_data("lsq_regs2_data_o", exp_data, lsq_regs2_data_o);
        // waiting instruction goes in, store strobe is gone
        accept_and_settle();
        check_zone_strobes(ZONE_REGFILE);
        check_data("ids_regd_data_o",
                   alu_model(XOR, ids_operand_left_i, ids_operand_right_i), ids_regd_data_o);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        reset_i             = 1'b1;
        lsq_full_i          = 1'b0;
        ids_valid_i         = 1'b0;
        ids_sofid_i         = SOFID_RUN;
        ids_jump_i          = 1'b0;
        ids_cond_i          = 1'b0;
        ids_link_i          = 1'b0;
        ids_zone_i          = ZONE_NONE;
        ids_alu_op_i        = ADD;
        ids_ins_size_i      = '0;
        ids_pc_i            = '0;
        ids_operand_left_i  = '0;
        ids_operand_right_i = '0;
        ids_cmp_right_i     = '0;
        ids_regs1_data_i    = '0;
        ids_regs2_data_i    = '0;
        ids_regd_addr_i     = '0;
        ids_funct3_i        = '0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        alu_writeback();
        branch_compare();
        jump_and_link();
        load_store_access();
        queue_back_pressure();
        errors += int'(i_ex_stage.i_ex_stage_chk.fail_count);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD_NS);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

endmodule
